/* build.f */
rtl/demo_sys_pkg.sv
rtl/demo_bus.sv
rtl/demo_ram.sv
rtl/demo_gpio.sv
rtl/demo_timer.sv
rtl/demo_system.sv
sim/tb_demo_system.sv

/* Bender.yml */
package:
  name: demo_system

sources:
  - rtl/demo_sys_pkg.sv
  - rtl/demo_bus.sv
  - rtl/demo_ram.sv
  - rtl/demo_gpio.sv
  - rtl/demo_timer.sv
  - rtl/demo_system.sv
  - target: simulation
    files:
      - sim/tb_demo_system.sv

/* sim/tb_demo_system.sv */
// testbench for demo_system, host port and fetch port driven directly
// every RAM word gets a full write before partial writes or fetches use it
`timescale 1ns/1ps

module tb_demo_system;

  localparam logic [31:0] seed_init  = 32'h7ce8;
  localparam int          nr_words   = 8;
  localparam int          nr_partial = 16;
  localparam int          wait_limit = 50;
  localparam int          irq_limit  = 20;

  logic        clk_sys_i;
  logic        rst_sys_ni;
  logic        host_req_i;
  logic [31:0] host_addr_i;
  logic        host_we_i;
  logic [3:0]  host_be_i;
  logic [31:0] host_wdata_i;
  logic        host_gnt_o;
  logic        host_rvalid_o;
  logic [31:0] host_rdata_o;
  logic        host_err_o;
  logic        instr_req_i;
  logic [31:0] instr_addr_i;
  logic        instr_gnt_o;
  logic        instr_rvalid_o;
  logic [31:0] instr_rdata_o;
  logic [7:0]  gp_i;
  logic [15:0] gp_o;
  logic        timer_irq_o;

  // reference state
  logic [31:0] ram_model [int];
  logic [15:0] gpo_model;
  logic [7:0]  gpi_model;

  // predictions, one entry per accepted request
  logic [31:0] exp_data_q [$];
  logic        exp_err_q  [$];
  logic        exp_chk_q  [$];
  int          exp_cyc_q  [$];

  logic [31:0] p_data;
  logic        p_err;
  logic        p_chk;
  logic [31:0] last_rdata;
  logic [31:0] seed;
  logic [31:0] addr_list [nr_words];
  int          cyc;
  int          pass_cnt;
  int          fail_cnt;

  demo_system u_demo_system (.*);

  always #5 clk_sys_i = ~clk_sys_i;

  always @(posedge clk_sys_i) begin
    cyc <= cyc + 1;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // expected response of one request, updates the model on writes
  function automatic void predict(input logic [31:0] addr, input logic we,
                                  input logic [3:0] be, input logic [31:0] wdata,
                                  output logic [31:0] data, output logic err,
                                  output logic chk);
    logic [31:0] word;
    data = '0;
    err  = 1'b0;
    chk  = 1'b1;
    if ((addr & demo_sys_pkg::ram_mask) == demo_sys_pkg::ram_start) begin
      word = ram_model.exists(int'(addr[15:2])) ? ram_model[int'(addr[15:2])] : '0;
      if (we) begin
        for (int b = 0; b < 4; b++) begin
          if (be[b]) word[b*8 +: 8] = wdata[b*8 +: 8];
        end
        ram_model[int'(addr[15:2])] = word;
      end else begin
        // unwritten words hold no known value
        chk  = ram_model.exists(int'(addr[15:2]));
        data = word;
      end
    end else if ((addr & demo_sys_pkg::gpio_mask) == demo_sys_pkg::gpio_start) begin
      if (addr[11:0] == demo_sys_pkg::gpio_out_off) begin
        if (we) begin
          for (int b = 0; b < 2; b++) begin
            if (be[b]) gpo_model[b*8 +: 8] = wdata[b*8 +: 8];
          end
        end else begin
          data = {16'h0000, gpo_model};
        end
      end else if (addr[11:0] == demo_sys_pkg::gpio_in_off && !we) begin
        data = {24'h000000, gpi_model};
      end
    end else if ((addr & demo_sys_pkg::timer_mask) == demo_sys_pkg::timer_start) begin
      // free-running counter, read data checked by the test itself
      chk = we;
    end else begin
      err = 1'b1;
    end
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) pass_cnt++;
    else begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      fail_cnt++;
    end
  endtask

  // compare responses mid-cycle, when all outputs are settled
  always @(negedge clk_sys_i) begin
    if (rst_sys_ni) begin
      check_value("host_gnt_o", host_gnt_o, host_req_i);
      if (host_rvalid_o) begin
        assert (exp_cyc_q.size() != 0) pass_cnt++;
        else begin
          $display("host_rvalid_o pulsed at %0t with no request pending", $time);
          fail_cnt++;
        end
        if (exp_cyc_q.size() != 0) begin
          check_value("rvalid cycle", cyc, exp_cyc_q[0]);
          check_value("host_err_o", host_err_o, exp_err_q[0]);
          if (exp_chk_q[0]) check_value("host_rdata_o", host_rdata_o, exp_data_q[0]);
          last_rdata = host_rdata_o;
          void'(exp_data_q.pop_front());
          void'(exp_err_q.pop_front());
          void'(exp_chk_q.pop_front());
          void'(exp_cyc_q.pop_front());
        end
      end
      // new request answers in the next cycle
      if (host_req_i) begin
        predict(host_addr_i, host_we_i, host_be_i, host_wdata_i, p_data, p_err, p_chk);
        exp_data_q.push_back(p_data);
        exp_err_q.push_back(p_err);
        exp_chk_q.push_back(p_chk);
        exp_cyc_q.push_back(cyc + 1);
      end
    end
  end

  task automatic issue(input logic [31:0] addr, input logic we, input logic [3:0] be,
                       input logic [31:0] wdata);
    @(posedge clk_sys_i);
    host_req_i   <= 1'b1;
    host_addr_i  <= addr;
    host_we_i    <= we;
    host_be_i    <= be;
    host_wdata_i <= wdata;
  endtask

  // stop requesting and wait until every response is back
  task automatic drain();
    int n;
    n = 0;
    @(posedge clk_sys_i);
    host_req_i <= 1'b0;
    while (exp_cyc_q.size() != 0 && n < wait_limit) begin
      @(negedge clk_sys_i);
      n++;
    end
    assert (exp_cyc_q.size() == 0) pass_cnt++;
    else begin
      $display("timeout: %0d bus responses still missing at %0t", exp_cyc_q.size(), $time);
      fail_cnt++;
    end
  endtask

  task automatic fetch(input logic [31:0] addr, input logic exp_gnt,
                       input logic [31:0] exp_word);
    int n;
    @(posedge clk_sys_i);
    instr_req_i  <= 1'b1;
    instr_addr_i <= addr;
    @(negedge clk_sys_i);
    check_value("instr_gnt_o", instr_gnt_o, exp_gnt);
    @(posedge clk_sys_i);
    instr_req_i <= 1'b0;
    @(negedge clk_sys_i);
    n = 1;
    if (!exp_gnt) begin
      check_value("instr_rvalid_o", instr_rvalid_o, 1'b0);
    end else begin
      while (!instr_rvalid_o && n < wait_limit) begin
        @(negedge clk_sys_i);
        n++;
      end
      assert (instr_rvalid_o) pass_cnt++;
      else begin
        $display("timeout: no instr_rvalid_o for fetch at %h", addr);
        fail_cnt++;
      end
      check_value("fetch latency", n, 1);
      check_value("instr_rdata_o", instr_rdata_o, exp_word);
    end
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while (timer_irq_o !== level && n < irq_limit) begin
      @(negedge clk_sys_i);
      n++;
    end
    assert (timer_irq_o === level) pass_cnt++;
    else begin
      $display("timeout: timer_irq_o did not go to %0b within %0d cycles", level, irq_limit);
      fail_cnt++;
    end
  endtask

  task automatic finish_test(input string name, input int fails_before);
    $display("test %s finished with %0d failed checks", name, fail_cnt - fails_before);
  endtask

  initial begin
    int          fails_before;
    int          idx;
    logic [31:0] t_first;
    logic [31:0] t_second;
    clk_sys_i    = 1'b0;
    rst_sys_ni   = 1'b0;
    host_req_i   = 1'b0;
    host_addr_i  = '0;
    host_we_i    = 1'b0;
    host_be_i    = '0;
    host_wdata_i = '0;
    instr_req_i  = 1'b0;
    instr_addr_i = '0;
    gp_i         = '0;
    gpo_model    = '0;
    gpi_model    = '0;
    cyc          = 0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    seed         = seed_init;
    repeat (3) @(posedge clk_sys_i);
    rst_sys_ni <= 1'b1;

    // full words first, then random partial merges, then reads
    fails_before = fail_cnt;
    for (int i = 0; i < nr_words; i++) begin
      seed = xorshift(seed);
      addr_list[i] = {16'h0000, seed[15:2], 2'b00};
      seed = xorshift(seed);
      issue(addr_list[i], 1'b1, 4'hf, seed);
    end
    for (int i = 0; i < nr_partial; i++) begin
      seed = xorshift(seed);
      idx = int'(seed % nr_words);
      issue(addr_list[idx], 1'b1, seed[7:4], xorshift(seed));
    end
    for (int i = 0; i < nr_words; i++) begin
      issue(addr_list[i], 1'b0, 4'hf, '0);
    end
    drain();
    finish_test("ram data path", fails_before);

    fails_before = fail_cnt;
    for (int i = 0; i < 4; i++) begin
      seed = xorshift(seed);
      issue(32'h100 + 32'(4 * i), 1'b1, 4'hf, seed);
    end
    drain();
    for (int i = 0; i < 4; i++) begin
      fetch(32'h100 + 32'(4 * i), 1'b1, ram_model[64 + i]);
    end
    fetch(addr_list[0], 1'b1, ram_model[int'(addr_list[0][15:2])]);
    fetch(32'h80000000, 1'b0, '0);
    finish_test("instruction fetch", fails_before);

    // 0x40000010 would alias word 0x10 if decoded by low bits only
    fails_before = fail_cnt;
    issue(32'h00000010, 1'b1, 4'hf, 32'h11112222);
    issue(32'h40000010, 1'b1, 4'hf, 32'hdeadbeef);
    issue(32'h40000010, 1'b0, 4'hf, '0);
    issue(32'h00000010, 1'b0, 4'hf, '0);
    drain();
    finish_test("unmapped access", fails_before);

    fails_before = fail_cnt;
    issue(demo_sys_pkg::gpio_start + demo_sys_pkg::gpio_out_off, 1'b1, 4'b0011, 32'hffffffff);
    issue(demo_sys_pkg::gpio_start + demo_sys_pkg::gpio_out_off, 1'b1, 4'b0010, 32'h12345678);
    issue(demo_sys_pkg::gpio_start + demo_sys_pkg::gpio_out_off, 1'b1, 4'b1101, 32'habcd0099);
    drain();
    check_value("gp_o", gp_o, gpo_model);
    issue(demo_sys_pkg::gpio_start + demo_sys_pkg::gpio_out_off, 1'b0, 4'hf, '0);
    issue(demo_sys_pkg::gpio_start + 32'h8, 1'b0, 4'hf, '0);
    drain();
    // held through the synchronizer before the read
    @(posedge clk_sys_i);
    gp_i <= 8'h5a;
    gpi_model = 8'h5a;
    repeat (3) @(posedge clk_sys_i);
    issue(demo_sys_pkg::gpio_start + demo_sys_pkg::gpio_in_off, 1'b0, 4'hf, '0);
    drain();
    finish_test("gpio", fails_before);

    fails_before = fail_cnt;
    check_value("timer_irq_o", timer_irq_o, 1'b0);
    issue(demo_sys_pkg::timer_start + demo_sys_pkg::timer_mtime_lo_off, 1'b0, 4'hf, '0);
    drain();
    t_first = last_rdata;
    issue(demo_sys_pkg::timer_start + demo_sys_pkg::timer_mtime_lo_off, 1'b0, 4'hf, '0);
    drain();
    t_second = last_rdata;
    assert (t_second > t_first) pass_cnt++;
    else begin
      $display("Mismatch at %0t: mtime read %h after %h", $time, t_second, t_first);
      fail_cnt++;
    end
    // compare of zero fires at once
    issue(demo_sys_pkg::timer_start + demo_sys_pkg::timer_cmp_lo_off, 1'b1, 4'hf, '0);
    issue(demo_sys_pkg::timer_start + demo_sys_pkg::timer_cmp_hi_off, 1'b1, 4'hf, '0);
    drain();
    wait_irq(1'b1);
    issue(demo_sys_pkg::timer_start + demo_sys_pkg::timer_cmp_hi_off, 1'b1, 4'hf, '1);
    drain();
    wait_irq(1'b0);
    finish_test("timer", fails_before);

    $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* rtl/demo_system.sv */
// demo system without a core, the host port replaces the core data port
// instruction fetches go straight to the RAM second port
`timescale 1ns/1ps

module demo_system (
  input  logic                                clk_sys_i,
  input  logic                                rst_sys_ni,

  input  logic                                host_req_i,
  input  logic [demo_sys_pkg::addr_width-1:0] host_addr_i,
  input  logic                                host_we_i,
  input  logic [demo_sys_pkg::be_width-1:0]   host_be_i,
  input  logic [demo_sys_pkg::data_width-1:0] host_wdata_i,
  output logic                                host_gnt_o,
  output logic                                host_rvalid_o,
  output logic [demo_sys_pkg::data_width-1:0] host_rdata_o,
  output logic                                host_err_o,

  input  logic                                instr_req_i,
  input  logic [demo_sys_pkg::addr_width-1:0] instr_addr_i,
  output logic                                instr_gnt_o,
  output logic                                instr_rvalid_o,
  output logic [demo_sys_pkg::data_width-1:0] instr_rdata_o,

  input  logic [demo_sys_pkg::gpi_width-1:0]  gp_i,
  output logic [demo_sys_pkg::gpo_width-1:0]  gp_o,

  output logic                                timer_irq_o
);

  // bus to device wires
  logic                                dev_req    [demo_sys_pkg::nr_devices];
  logic [demo_sys_pkg::addr_width-1:0] dev_addr;
  logic                                dev_we;
  logic [demo_sys_pkg::be_width-1:0]   dev_be;
  logic [demo_sys_pkg::data_width-1:0] dev_wdata;
  logic                                dev_rvalid [demo_sys_pkg::nr_devices];
  logic [demo_sys_pkg::data_width-1:0] dev_rdata  [demo_sys_pkg::nr_devices];

  demo_bus u_bus (
    .clk_sys_i, .rst_sys_ni,
    .host_req_i, .host_addr_i, .host_we_i, .host_be_i, .host_wdata_i,
    .host_gnt_o, .host_rvalid_o, .host_rdata_o, .host_err_o,
    .dev_req_o   (dev_req),
    .dev_addr_o  (dev_addr),
    .dev_we_o    (dev_we),
    .dev_be_o    (dev_be),
    .dev_wdata_o (dev_wdata),
    .dev_rvalid_i(dev_rvalid),
    .dev_rdata_i (dev_rdata)
  );

  demo_ram u_ram (
    .clk_sys_i, .rst_sys_ni,
    .req_i   (dev_req[demo_sys_pkg::ram]),
    .addr_i  (dev_addr),
    .we_i    (dev_we),
    .be_i    (dev_be),
    .wdata_i (dev_wdata),
    .rvalid_o(dev_rvalid[demo_sys_pkg::ram]),
    .rdata_o (dev_rdata[demo_sys_pkg::ram]),
    .instr_req_i, .instr_addr_i, .instr_gnt_o, .instr_rvalid_o, .instr_rdata_o
  );

  demo_gpio u_gpio (
    .clk_sys_i, .rst_sys_ni,
    .req_i   (dev_req[demo_sys_pkg::gpio]),
    .addr_i  (dev_addr),
    .we_i    (dev_we),
    .be_i    (dev_be),
    .wdata_i (dev_wdata),
    .rvalid_o(dev_rvalid[demo_sys_pkg::gpio]),
    .rdata_o (dev_rdata[demo_sys_pkg::gpio]),
    .gp_i, .gp_o
  );

  demo_timer u_timer (
    .clk_sys_i, .rst_sys_ni,
    .req_i   (dev_req[demo_sys_pkg::timer]),
    .addr_i  (dev_addr),
    .we_i    (dev_we),
    .be_i    (dev_be),
    .wdata_i (dev_wdata),
    .rvalid_o(dev_rvalid[demo_sys_pkg::timer]),
    .rdata_o (dev_rdata[demo_sys_pkg::timer]),
    .timer_irq_o
  );

endmodule

/* rtl/demo_timer.sv */
// 64-bit mtime counting every clock, mtimecmp and a level interrupt
// software writing mtime should write one half at a time, low first
// irq follows the compare one cycle late
`timescale 1ns/1ps

module demo_timer (
  input  logic                                clk_sys_i,
  input  logic                                rst_sys_ni,

  input  logic                                req_i,
  input  logic [demo_sys_pkg::addr_width-1:0] addr_i,
  input  logic                                we_i,
  input  logic [demo_sys_pkg::be_width-1:0]   be_i,
  input  logic [demo_sys_pkg::data_width-1:0] wdata_i,
  output logic                                rvalid_o,
  output logic [demo_sys_pkg::data_width-1:0] rdata_o,

  output logic                                timer_irq_o
);

  logic [63:0]                         mtime_q;
  logic [63:0]                         mtimecmp_q;
  logic                                wr;
  logic                                wr_mtime_lo;
  logic                                wr_mtime_hi;
  logic                                wr_cmp_lo;
  logic                                wr_cmp_hi;
  logic [demo_sys_pkg::data_width-1:0] rdata_d;

  assign wr = req_i && we_i;

  // register select by word offset
  assign wr_mtime_lo = wr && (addr_i[11:2] == demo_sys_pkg::timer_mtime_lo_off[11:2]);
  assign wr_mtime_hi = wr && (addr_i[11:2] == demo_sys_pkg::timer_mtime_hi_off[11:2]);
  assign wr_cmp_lo   = wr && (addr_i[11:2] == demo_sys_pkg::timer_cmp_lo_off[11:2]);
  assign wr_cmp_hi   = wr && (addr_i[11:2] == demo_sys_pkg::timer_cmp_hi_off[11:2]);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q     <= '0;
      // all ones keeps the irq low until software sets a compare
      mtimecmp_q  <= '1;
      timer_irq_o <= 1'b0;
      rvalid_o    <= 1'b0;
    end else begin
      rvalid_o    <= req_i;
      timer_irq_o <= mtime_q >= mtimecmp_q;
      // a write stalls the count for that cycle
      if (wr_mtime_lo) begin
        mtime_q[31:0] <= wdata_i;
      end else if (wr_mtime_hi) begin
        mtime_q[63:32] <= wdata_i;
      end else begin
        mtime_q <= mtime_q + 64'd1;
      end
      // compare halves take byte enables
      for (int b = 0; b < demo_sys_pkg::be_width; b++) begin
        if (wr_cmp_lo && be_i[b]) begin
          mtimecmp_q[b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
        if (wr_cmp_hi && be_i[b]) begin
          mtimecmp_q[32 + b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // read mux, unknown offsets read zero
  always_comb begin
    rdata_d = '0;
    case (addr_i[11:2])
      demo_sys_pkg::timer_mtime_lo_off[11:2]: rdata_d = mtime_q[31:0];
      demo_sys_pkg::timer_mtime_hi_off[11:2]: rdata_d = mtime_q[63:32];
      demo_sys_pkg::timer_cmp_lo_off[11:2]:   rdata_d = mtimecmp_q[31:0];
      demo_sys_pkg::timer_cmp_hi_off[11:2]:   rdata_d = mtimecmp_q[63:32];
      default:                                rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i && !we_i) begin
      rdata_o <= rdata_d;
    end
  end

  a_mtime_monotonic: assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni)
    !$past(wr_mtime_lo || wr_mtime_hi) |-> (mtime_q >= $past(mtime_q))
  ) else $error("mtime went backwards without a write");

endmodule

/* rtl/demo_gpio.sv */
// gpio with a byte writable output register and synchronized inputs
// inputs need 3 stable cycles before a read sees them
`timescale 1ns/1ps

module demo_gpio (
  input  logic                                clk_sys_i,
  input  logic                                rst_sys_ni,

  input  logic                                req_i,
  input  logic [demo_sys_pkg::addr_width-1:0] addr_i,
  input  logic                                we_i,
  input  logic [demo_sys_pkg::be_width-1:0]   be_i,
  input  logic [demo_sys_pkg::data_width-1:0] wdata_i,
  output logic                                rvalid_o,
  output logic [demo_sys_pkg::data_width-1:0] rdata_o,

  input  logic [demo_sys_pkg::gpi_width-1:0]  gp_i,
  output logic [demo_sys_pkg::gpo_width-1:0]  gp_o
);

  logic [demo_sys_pkg::gpi_width-1:0]  gp_meta_q;
  logic [demo_sys_pkg::gpi_width-1:0]  gp_sync_q;
  logic                                sel_out;
  logic                                sel_in;
  logic [demo_sys_pkg::data_width-1:0] rdata_d;

  // word decode inside the 4 KiB window
  assign sel_out = addr_i[11:2] == demo_sys_pkg::gpio_out_off[11:2];
  assign sel_in  = addr_i[11:2] == demo_sys_pkg::gpio_in_off[11:2];

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_o      <= '0;
      gp_meta_q <= '0;
      gp_sync_q <= '0;
      rvalid_o  <= 1'b0;
    end else begin
      // 2-flop synchronizer
      gp_meta_q <= gp_i;
      gp_sync_q <= gp_meta_q;
      rvalid_o  <= req_i;
      // only the bytes that exist in gp_o
      if (req_i && we_i && sel_out) begin
        for (int b = 0; b < demo_sys_pkg::gpo_width / 8; b++) begin
          if (be_i[b]) begin
            gp_o[b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end
    end
  end

  // read mux, unknown offsets give zero
  always_comb begin
    rdata_d = '0;
    if (sel_out) begin
      rdata_d[demo_sys_pkg::gpo_width-1:0] = gp_o;
    end else if (sel_in) begin
      rdata_d[demo_sys_pkg::gpi_width-1:0] = gp_sync_q;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i && !we_i) begin
      rdata_o <= rdata_d;
    end
  end

endmodule

/* rtl/demo_ram.sv */
// dual port word RAM, contents undefined after reset
// data port indexes by word, region check is left to the bus
// instruction port grants only fetches inside the RAM region
`timescale 1ns/1ps

module demo_ram (
  input  logic                                clk_sys_i,
  input  logic                                rst_sys_ni,

  input  logic                                req_i,
  input  logic [demo_sys_pkg::addr_width-1:0] addr_i,
  input  logic                                we_i,
  input  logic [demo_sys_pkg::be_width-1:0]   be_i,
  input  logic [demo_sys_pkg::data_width-1:0] wdata_i,
  output logic                                rvalid_o,
  output logic [demo_sys_pkg::data_width-1:0] rdata_o,

  input  logic                                instr_req_i,
  input  logic [demo_sys_pkg::addr_width-1:0] instr_addr_i,
  output logic                                instr_gnt_o,
  output logic                                instr_rvalid_o,
  output logic [demo_sys_pkg::data_width-1:0] instr_rdata_o
);

  logic [demo_sys_pkg::data_width-1:0] mem [demo_sys_pkg::ram_depth];

  // word index, byte offset dropped
  logic [$clog2(demo_sys_pkg::ram_depth)-1:0] d_idx;
  logic [$clog2(demo_sys_pkg::ram_depth)-1:0] i_idx;

  assign d_idx = addr_i[$clog2(demo_sys_pkg::ram_depth)+1:2];
  assign i_idx = instr_addr_i[$clog2(demo_sys_pkg::ram_depth)+1:2];

  // fetch grant from region match
  assign instr_gnt_o = instr_req_i &&
      ((instr_addr_i & demo_sys_pkg::ram_mask) == demo_sys_pkg::ram_start);

  // storage and read data
  always_ff @(posedge clk_sys_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < demo_sys_pkg::be_width; b++) begin
        if (be_i[b]) begin
          mem[d_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
    // read before write on the same word
    if (req_i && !we_i) begin
      rdata_o <= mem[d_idx];
    end
    if (instr_gnt_o) begin
      instr_rdata_o <= mem[i_idx];
    end
  end

  // one cycle response on both ports
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_o       <= 1'b0;
      instr_rvalid_o <= 1'b0;
    end else begin
      rvalid_o       <= req_i;
      instr_rvalid_o <= instr_gnt_o;
    end
  end

  a_instr_rvalid_after_gnt: assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni)
    instr_rvalid_o |-> $past(instr_gnt_o)
  ) else $error("instr_rvalid without grant");

endmodule

/* rtl/demo_bus.sv */
// single host bus that grants every request in the cycle it is made
// devices must answer exactly one cycle after their req
// unmapped addresses get an err response from the bus itself
`timescale 1ns/1ps

module demo_bus (
  input  logic                                clk_sys_i,
  input  logic                                rst_sys_ni,

  input  logic                                host_req_i,
  input  logic [demo_sys_pkg::addr_width-1:0] host_addr_i,
  input  logic                                host_we_i,
  input  logic [demo_sys_pkg::be_width-1:0]   host_be_i,
  input  logic [demo_sys_pkg::data_width-1:0] host_wdata_i,
  output logic                                host_gnt_o,
  output logic                                host_rvalid_o,
  output logic [demo_sys_pkg::data_width-1:0] host_rdata_o,
  output logic                                host_err_o,

  output logic                                dev_req_o    [demo_sys_pkg::nr_devices],
  output logic [demo_sys_pkg::addr_width-1:0] dev_addr_o,
  output logic                                dev_we_o,
  output logic [demo_sys_pkg::be_width-1:0]   dev_be_o,
  output logic [demo_sys_pkg::data_width-1:0] dev_wdata_o,
  input  logic                                dev_rvalid_i [demo_sys_pkg::nr_devices],
  input  logic [demo_sys_pkg::data_width-1:0] dev_rdata_i  [demo_sys_pkg::nr_devices]
);

  logic [demo_sys_pkg::nr_devices-1:0] hit;
  logic [demo_sys_pkg::nr_devices-1:0] dev_req_vec;
  logic                                sel_hit;
  demo_sys_pkg::bus_device_e           sel_idx;

  // one stage of response routing state
  logic                      dev_q;
  logic                      err_q;
  logic                      we_q;
  demo_sys_pkg::bus_device_e idx_q;

  // region match per device
  assign hit[demo_sys_pkg::ram] =
      (host_addr_i & demo_sys_pkg::ram_mask) == demo_sys_pkg::ram_start;
  assign hit[demo_sys_pkg::gpio] =
      (host_addr_i & demo_sys_pkg::gpio_mask) == demo_sys_pkg::gpio_start;
  assign hit[demo_sys_pkg::timer] =
      (host_addr_i & demo_sys_pkg::timer_mask) == demo_sys_pkg::timer_start;

  // index of the lowest matching device for response routing
  always_comb begin
    sel_hit = 1'b0;
    sel_idx = demo_sys_pkg::ram;
    for (int i = demo_sys_pkg::nr_devices - 1; i >= 0; i--) begin
      if (hit[i]) begin
        sel_hit = 1'b1;
        sel_idx = demo_sys_pkg::bus_device_e'(i);
      end
    end
  end

  // no back-pressure and no second host
  assign host_gnt_o = host_req_i;

  // shared request payload
  assign dev_addr_o  = host_addr_i;
  assign dev_we_o    = host_we_i;
  assign dev_be_o    = host_be_i;
  assign dev_wdata_o = host_wdata_i;

  for (genvar i = 0; i < demo_sys_pkg::nr_devices; i++) begin : g_dev
    // request goes to every region that matches
    assign dev_req_vec[i] = host_req_i && hit[i];
    assign dev_req_o[i]   = dev_req_vec[i];

    // a device answers only what it was asked one cycle before
    a_rvalid_after_req: assert property (
      @(posedge clk_sys_i) disable iff (!rst_sys_ni)
      dev_rvalid_i[i] |-> $past(dev_req_vec[i])
    ) else $error("device %0d rvalid without request", i);
  end

  // remember who answers next cycle
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      dev_q <= 1'b0;
      err_q <= 1'b0;
      we_q  <= 1'b0;
      idx_q <= demo_sys_pkg::ram;
    end else begin
      dev_q <= host_req_i && sel_hit;
      err_q <= host_req_i && !sel_hit;
      we_q  <= host_we_i;
      if (host_req_i && sel_hit) begin
        idx_q <= sel_idx;
      end
    end
  end

  // the bus makes the error response and routes the rest from the device
  assign host_rvalid_o = err_q || (dev_q && dev_rvalid_i[idx_q]);
  assign host_err_o    = err_q;
  // writes return zero data
  assign host_rdata_o  = (dev_q && !we_q) ? dev_rdata_i[idx_q] : '0;

  a_dev_req_onehot: assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni)
    $onehot0(dev_req_vec)
  ) else $error("more than one device selected");

endmodule

/* rtl/demo_sys_pkg.sv */
// memory map and register offsets for the demo system
// register blocks decode address bits 11:2 only, so accesses are word aligned
// regions must not overlap and each size must be a power of two

package demo_sys_pkg;

  // bus widths
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int be_width   = 4;

  // gpio pin counts
  localparam int gpi_width = 8;
  localparam int gpo_width = 16;

  // device index on the bus, also the decode priority order
  typedef enum int {
    ram,
    gpio,
    timer
  } bus_device_e;

  localparam int nr_devices = 3;

  // ram region, 64 KiB at zero
  localparam logic [addr_width-1:0] ram_start = 32'h00000000;
  localparam logic [addr_width-1:0] ram_size  = 32'h00010000;
  localparam logic [addr_width-1:0] ram_mask  = ~(ram_size - 1);

  // words of 32 bits
  localparam int ram_depth = 16384;

  // gpio region, 4 KiB
  localparam logic [addr_width-1:0] gpio_start = 32'h80000000;
  localparam logic [addr_width-1:0] gpio_size  = 32'h00001000;
  localparam logic [addr_width-1:0] gpio_mask  = ~(gpio_size - 1);

  // timer region, 4 KiB
  localparam logic [addr_width-1:0] timer_start = 32'h80002000;
  localparam logic [addr_width-1:0] timer_size  = 32'h00001000;
  localparam logic [addr_width-1:0] timer_mask  = ~(timer_size - 1);

  // gpio registers
  localparam logic [11:0] gpio_out_off = 12'h000;
  localparam logic [11:0] gpio_in_off  = 12'h004;

  // timer registers, mtime then mtimecmp, low half first
  localparam logic [11:0] timer_mtime_lo_off = 12'h000;
  localparam logic [11:0] timer_mtime_hi_off = 12'h004;
  localparam logic [11:0] timer_cmp_lo_off   = 12'h008;
  localparam logic [11:0] timer_cmp_hi_off   = 12'h00c;

endpackage
